// File: hw/dtpu_pkg.sv
package dtpu_pkg;

    //////////////////////////////
    // Array geometry
    //////////////////////////////

    // 4x4 array of 4-bit lanes
    localparam int mxu_rows       = 4;
    localparam int mxu_cols       = 4;
    localparam int lane_width     = 4;
    // Full product of two lanes
    localparam int prod_width     = 2 * lane_width;
    // Four products summed, signed or unsigned
    localparam int acc_width      = 10;
    localparam int out_lane_width = 16;
    // One weight row, also the used part of an input word
    localparam int row_width      = mxu_cols * lane_width;
    localparam int word_width     = 64;

    // Memory and counter widths
    localparam int csr_addr_width = 10;
    localparam int wm_addr_width  = 13;
    localparam int count_width    = 8;

    //////////////////////////////
    // Plain vector types
    //////////////////////////////

    typedef logic [lane_width-1:0]     lane_t;
    typedef logic [acc_width-1:0]      acc_t;
    typedef logic [word_width-1:0]     word_t;
    typedef logic [count_width-1:0]    count_t;
    typedef logic [csr_addr_width-1:0] csr_addr_t;
    typedef logic [wm_addr_width-1:0]  wm_addr_t;

    // Job bytes in the CSR memory
    localparam csr_addr_t csr_off_count = csr_addr_t'(0);
    localparam csr_addr_t csr_off_index = csr_addr_t'(1);
    localparam csr_addr_t csr_off_type  = csr_addr_t'(2);

    typedef enum logic {
        dt_unsigned = 1'b0,
        dt_signed   = 1'b1
    } data_type_e;

    // Job configuration as read from the CSR bytes
    typedef struct packed {
        count_t     vec_count;
        wm_addr_t   matrix_index;
        data_type_e data_type;
    } job_cfg_t;

    // Control states, exported on the 4-bit state port
    typedef enum logic [3:0] {
        st_idle   = 4'd0,
        st_csr    = 4'd1,
        st_weight = 4'd2,
        st_run    = 4'd3,
        st_drain  = 4'd4,
        st_done   = 4'd5
    } cu_state_e;

endpackage

// File: hw/mac_row.sv
`timescale 1ns/1ps

module mac_row (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        advance,
    input  dtpu_pkg::data_type_e                        data_type,
    input  dtpu_pkg::lane_t [dtpu_pkg::mxu_cols-1:0]    weights,
    input  dtpu_pkg::lane_t [dtpu_pkg::mxu_cols-1:0]    vector,
    output dtpu_pkg::acc_t                              sum
);
    import dtpu_pkg::*;

    logic [mxu_cols-1:0][prod_width-1:0] prod_d;
    logic [mxu_cols-1:0][prod_width-1:0] prod_q;
    acc_t                                sum_d;

    // Stage 1 products
    // Operands widened to 8 bits first, low 8 bits of the product are exact
    always_comb begin
        for (int k = 0; k < mxu_cols; k++) begin
            if (data_type == dt_signed) begin
                prod_d[k] = $signed({{lane_width{weights[k][lane_width-1]}}, weights[k]})
                          * $signed({{lane_width{vector[k][lane_width-1]}}, vector[k]});
            end else begin
                prod_d[k] = {{lane_width{1'b0}}, weights[k]} * {{lane_width{1'b0}}, vector[k]};
            end
        end
    end

    // Stage 2 sum, products extended to the accumulator width
    always_comb begin
        sum_d = '0;
        for (int k = 0; k < mxu_cols; k++) begin
            if (data_type == dt_signed) begin
                sum_d = sum_d + {{(acc_width-prod_width){prod_q[k][prod_width-1]}}, prod_q[k]};
            end else begin
                sum_d = sum_d + {{(acc_width-prod_width){1'b0}}, prod_q[k]};
            end
        end
    end

    // Both stages move only with the pipeline
    always_ff @(posedge clk) begin
        if (reset) begin
            prod_q <= '0;
            sum    <= '0;
        end else if (advance) begin
            prod_q <= prod_d;
            sum    <= sum_d;
        end
    end

endmodule

// File: hw/mxu.sv
`timescale 1ns/1ps

module mxu (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 advance,
    input  logic                 weight_load,
    input  dtpu_pkg::word_t      weight_word,
    input  dtpu_pkg::data_type_e data_type,
    input  logic                 in_valid,
    input  dtpu_pkg::word_t      input_word,
    output logic                 out_valid,
    output dtpu_pkg::word_t      result_word
);
    import dtpu_pkg::*;

    word_t      weight_q;
    logic [1:0] valid_q;
    acc_t       row_sum [mxu_rows];

    //////////////////////////////
    // Weight matrix
    //////////////////////////////

    // Loaded once per job, row r in bits 16r+15..16r
    always_ff @(posedge clk) begin
        if (weight_load) begin
            weight_q <= weight_word;
        end
    end

    // Valid bit follows the two mac_row stages
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (advance) begin
            valid_q <= {valid_q[0], in_valid};
        end
    end

    assign out_valid = valid_q[1];

    //////////////////////////////
    // Rows and result packing
    //////////////////////////////

    for (genvar r = 0; r < mxu_rows; r++) begin : g_row
        // Same input vector for every row, upper input bits unused
        mac_row mac_row_i (
            .clk       (clk),
            .reset     (reset),
            .advance   (advance),
            .data_type (data_type),
            .weights   (weight_q[r*row_width +: row_width]),
            .vector    (input_word[row_width-1:0]),
            .sum       (row_sum[r])
        );

        // Sign or zero extension to a 16-bit output lane
        assign result_word[r*out_lane_width +: out_lane_width] =
            (data_type == dt_signed)
                ? {{(out_lane_width-acc_width){row_sum[r][acc_width-1]}}, row_sum[r]}
                : {{(out_lane_width-acc_width){1'b0}}, row_sum[r]};
    end

endmodule

// File: hw/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enable,
    // Host handshake
    input  logic                 cs_start,
    input  logic                 cs_continue,
    output logic                 cs_ready,
    output logic                 cs_done,
    output logic                 cs_idle,
    output dtpu_pkg::cu_state_e  state,
    // CSR memory
    output logic                 csr_ce,
    output dtpu_pkg::csr_addr_t  csr_address,
    input  logic [7:0]           csr_dout,
    // Weight memory
    output logic                 wm_ce,
    output dtpu_pkg::wm_addr_t   wm_address,
    // FIFOs
    input  logic                 infifo_is_empty,
    output logic                 infifo_read,
    input  logic                 outfifo_is_full,
    output logic                 outfifo_write,
    // To and from the mxu
    input  logic                 mxu_out_valid,
    output logic                 weight_load,
    output dtpu_pkg::data_type_e cfg_type,
    output logic                 advance,
    output logic                 in_valid
);
    import dtpu_pkg::*;

    cu_state_e  state_q;
    cu_state_e  state_d;
    // Sub-step, CSR read number in st_csr, read or load in st_weight
    logic [1:0] step_q;
    logic [1:0] step_d;
    job_cfg_t   cfg_q;
    count_t     read_cnt_q;
    count_t     write_cnt_q;
    // CSR read issued last cycle and its address
    logic       csr_rd_q;
    csr_addr_t  csr_rd_addr_q;
    logic       wm_rd_q;
    logic       job_start;

    //////////////////////////////
    // Stall and strobes
    //////////////////////////////

    // Whole core holds on enable low or a result stuck at a full FIFO
    assign advance = enable && !(mxu_out_valid && outfifo_is_full);

    assign outfifo_write = advance && mxu_out_valid;
    assign infifo_read   = in_valid;
    // Weight word on wm_dout one cycle after the read
    assign weight_load   = wm_rd_q;
    assign wm_address    = cfg_q.matrix_index;
    assign cfg_type      = cfg_q.data_type;

    assign state   = state_q;
    assign cs_idle = (state_q == st_idle);
    assign cs_done = (state_q == st_done);

    assign job_start = (state_q == st_idle) && (state_d == st_csr);

    //////////////////////////////
    // Next state
    //////////////////////////////

    always_comb begin
        state_d     = state_q;
        step_d      = step_q;
        csr_ce      = 1'b0;
        csr_address = csr_off_count;
        wm_ce       = 1'b0;
        in_valid    = 1'b0;
        cs_ready    = 1'b0;

        case (state_q)
            st_idle: begin
                // Acceptance issues the count read
                if (cs_start && advance) begin
                    csr_ce  = 1'b1;
                    state_d = st_csr;
                    step_d  = 2'd1;
                end
            end
            st_csr: begin
                csr_address = (step_q == 2'd1) ? csr_off_index : csr_off_type;
                csr_ce      = advance;
                if (advance) begin
                    if (step_q == 2'd2) begin
                        // Count already captured, an empty job is ready here
                        cs_ready = (cfg_q.vec_count == '0);
                        state_d  = st_weight;
                        step_d   = 2'd0;
                    end else begin
                        step_d = step_q + 2'd1;
                    end
                end
            end
            st_weight: begin
                if (advance) begin
                    if (step_q == 2'd0) begin
                        // Index byte was captured the cycle before
                        wm_ce  = 1'b1;
                        step_d = 2'd1;
                    end else begin
                        state_d = st_run;
                    end
                end
            end
            st_run: begin
                if (cfg_q.vec_count == '0) begin
                    if (advance) begin
                        state_d = st_drain;
                    end
                end else begin
                    in_valid = advance && !infifo_is_empty;
                    // Last vector of the job
                    if (in_valid && (read_cnt_q == count_t'(cfg_q.vec_count - 8'd1))) begin
                        cs_ready = 1'b1;
                        state_d  = st_drain;
                    end
                end
            end
            st_drain: begin
                if (advance && (write_cnt_q == cfg_q.vec_count)) begin
                    state_d = st_done;
                end
            end
            st_done: begin
                if (advance && cs_continue) begin
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    //////////////////////////////
    // Registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q     <= st_idle;
            step_q      <= '0;
            cfg_q       <= '0;
            read_cnt_q  <= '0;
            write_cnt_q <= '0;
            csr_rd_q    <= 1'b0;
            wm_rd_q     <= 1'b0;
        end else begin
            state_q  <= state_d;
            step_q   <= step_d;
            csr_rd_q <= csr_ce;
            wm_rd_q  <= wm_ce;

            // Byte capture one cycle after each CSR read
            if (csr_rd_q) begin
                case (csr_rd_addr_q)
                    csr_off_count: cfg_q.vec_count    <= count_t'(csr_dout);
                    csr_off_index: cfg_q.matrix_index <= wm_addr_t'(csr_dout);
                    csr_off_type:  cfg_q.data_type    <= data_type_e'(csr_dout[0]);
                    default:       cfg_q              <= cfg_q;
                endcase
            end

            // Vectors read and results written in this job
            if (job_start) begin
                read_cnt_q  <= '0;
                write_cnt_q <= '0;
            end else begin
                if (in_valid) begin
                    read_cnt_q <= read_cnt_q + count_t'(1);
                end
                if (outfifo_write) begin
                    write_cnt_q <= write_cnt_q + count_t'(1);
                end
            end
        end
    end

    // Address of the pending CSR read
    always_ff @(posedge clk) begin
        if (csr_ce) begin
            csr_rd_addr_q <= csr_address;
        end
    end

endmodule

// File: hw/dtpu_core.sv
`timescale 1ns/1ps

module dtpu_core (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    //////////////////////////////
    // Host control
    //////////////////////////////
    input  logic                cs_start,
    input  logic                cs_continue,
    output logic                cs_ready,
    output logic                cs_done,
    output logic                cs_idle,
    output logic [3:0]          state,
    //////////////////////////////
    // CSR and weight memories
    //////////////////////////////
    output logic                csr_ce,
    output dtpu_pkg::csr_addr_t csr_address,
    input  logic [7:0]          csr_dout,
    output logic                wm_ce,
    output dtpu_pkg::wm_addr_t  wm_address,
    input  dtpu_pkg::word_t     wm_dout,
    //////////////////////////////
    // Data FIFOs
    //////////////////////////////
    // Input side is first-word fall-through
    input  logic                infifo_is_empty,
    input  dtpu_pkg::word_t     infifo_dout,
    output logic                infifo_read,
    input  logic                outfifo_is_full,
    output dtpu_pkg::word_t     outfifo_din,
    output logic                outfifo_write
);
    import dtpu_pkg::*;

    logic       weight_load;
    data_type_e cfg_type;
    logic       advance;
    logic       in_valid;
    logic       mxu_out_valid;

    // Job sequencing, memory reads and FIFO strobes
    control_unit control_unit_i (
        .clk             (clk),
        .reset           (reset),
        .enable          (enable),
        .cs_start        (cs_start),
        .cs_continue     (cs_continue),
        .cs_ready        (cs_ready),
        .cs_done         (cs_done),
        .cs_idle         (cs_idle),
        .state           (state),
        .csr_ce          (csr_ce),
        .csr_address     (csr_address),
        .csr_dout        (csr_dout),
        .wm_ce           (wm_ce),
        .wm_address      (wm_address),
        .infifo_is_empty (infifo_is_empty),
        .infifo_read     (infifo_read),
        .outfifo_is_full (outfifo_is_full),
        .outfifo_write   (outfifo_write),
        .mxu_out_valid   (mxu_out_valid),
        .weight_load     (weight_load),
        .cfg_type        (cfg_type),
        .advance         (advance),
        .in_valid        (in_valid)
    );

    // Matrix-vector datapath, result goes straight to the output FIFO
    mxu mxu_i (
        .clk         (clk),
        .reset       (reset),
        .advance     (advance),
        .weight_load (weight_load),
        .weight_word (wm_dout),
        .data_type   (cfg_type),
        .in_valid    (in_valid),
        .input_word  (infifo_dout),
        .out_valid   (mxu_out_valid),
        .result_word (outfifo_din)
    );

endmodule

// File: verification/dtpu_checker.sv
`timescale 1ns/1ps

module dtpu_checker (
    input  logic                 clk,
    input  logic                 reset,
    input  dtpu_pkg::word_t      job_matrix,
    input  dtpu_pkg::data_type_e job_type,
    input  logic                 infifo_read,
    input  dtpu_pkg::word_t      infifo_dout,
    input  logic                 outfifo_write,
    input  dtpu_pkg::word_t      outfifo_din,
    output int                   error_count,
    output int                   read_count,
    output int                   write_count,
    output int                   pending
);
    import dtpu_pkg::*;

    // Expected results, oldest input vector first
    word_t expected_q [$];

    // Matrix times vector from the packing rules, lanes extended to 16 bits
    function automatic word_t ref_result(word_t matrix, word_t vec, data_type_e dtype);
        word_t result;
        int    acc;
        int    w;
        int    x;
        result = '0;
        for (int r = 0; r < mxu_rows; r++) begin
            acc = 0;
            for (int c = 0; c < mxu_cols; c++) begin
                w = int'(matrix[out_lane_width*r + lane_width*c +: lane_width]);
                x = int'(vec[lane_width*c +: lane_width]);
                // Two's complement view of each lane
                if (dtype == dt_signed) begin
                    if (w >= 2 ** (lane_width - 1)) begin
                        w = w - 2 ** lane_width;
                    end
                    if (x >= 2 ** (lane_width - 1)) begin
                        x = x - 2 ** lane_width;
                    end
                end
                acc += w * x;
            end
            // Truncation of a negative int gives the sign extension
            result[out_lane_width*r +: out_lane_width] = out_lane_width'(acc);
        end
        return result;
    endfunction

    always @(posedge clk) begin
        word_t expected;
        if (reset) begin
            expected_q.delete();
            error_count = 0;
            read_count  = 0;
            write_count = 0;
        end else begin
            // Reads push before writes pop, the pipeline is never empty-to-out in one cycle
            if (infifo_read) begin
                expected_q.push_back(ref_result(job_matrix, infifo_dout, job_type));
                read_count++;
            end
            if (outfifo_write) begin
                write_count++;
                if (expected_q.size() == 0) begin
                    $display("Output FIFO written while no input vector was pending");
                    error_count++;
                end else begin
                    expected = expected_q.pop_front();
                    if (outfifo_din !== expected) begin
                        $display("ERR outfifo_din: got %h, expected %h", outfifo_din, expected);
                        error_count++;
                    end
                end
            end
        end
        pending = expected_q.size();
    end

endmodule

// File: verification/dtpu_assert.sv
`timescale 1ns/1ps

module dtpu_assert (
    input logic clk,
    input logic reset,
    input logic enable,
    input logic cs_done,
    input logic cs_continue,
    input logic csr_ce,
    input logic wm_ce,
    input logic infifo_read,
    input logic infifo_is_empty,
    input logic outfifo_write,
    input logic outfifo_is_full
);
    // Running count of failed properties
    int fail_count = 0;

    //////////////////////////////
    // FIFO rules
    //////////////////////////////

    a_read_not_empty: assert property (@(posedge clk) disable iff (reset)
        infifo_read |-> !infifo_is_empty)
        else begin
            fail_count++;
            $error("input FIFO read while empty");
        end

    a_write_not_full: assert property (@(posedge clk) disable iff (reset)
        outfifo_write |-> !outfifo_is_full)
        else begin
            fail_count++;
            $error("output FIFO written while full");
        end

    //////////////////////////////
    // Handshake and enable
    //////////////////////////////

    // Done stays up until the host continues
    a_done_hold: assert property (@(posedge clk) disable iff (reset)
        cs_done && !cs_continue |=> cs_done)
        else begin
            fail_count++;
            $error("cs_done dropped before cs_continue");
        end

    // Frozen core issues no strobes
    a_enable_freeze: assert property (@(posedge clk) disable iff (reset)
        !enable |-> !(infifo_read || outfifo_write || csr_ce || wm_ce))
        else begin
            fail_count++;
            $error("strobe active while enable was low");
        end

endmodule

bind dtpu_core dtpu_assert dtpu_assert_i (
    .clk             (clk),
    .reset           (reset),
    .enable          (enable),
    .cs_done         (cs_done),
    .cs_continue     (cs_continue),
    .csr_ce          (csr_ce),
    .wm_ce           (wm_ce),
    .infifo_read     (infifo_read),
    .infifo_is_empty (infifo_is_empty),
    .outfifo_write   (outfifo_write),
    .outfifo_is_full (outfifo_is_full)
);

// File: verification/dtpu_tb.sv
`timescale 1ns/1ps

module dtpu_tb;
    import dtpu_pkg::*;

    localparam int num_jobs = 8;

    logic       clk = 1'b0;
    logic       reset, enable, cs_start, cs_continue;
    logic       cs_ready, cs_done, cs_idle;
    logic [3:0] state;
    logic       csr_ce, wm_ce, infifo_is_empty, infifo_read, outfifo_is_full, outfifo_write;
    logic [7:0] csr_dout;
    csr_addr_t  csr_address;
    wm_addr_t   wm_address;
    word_t      wm_dout, infifo_dout, outfifo_din;

    // Memory and FIFO models
    logic [7:0] csr_mem [0:1023];
    word_t      wm_mem [0:8191];
    csr_addr_t  csr_rd_addr = '0;
    wm_addr_t   wm_rd_addr = '0;
    word_t      in_queue [$];
    bit         stress = 1'b0;

    // Current job as seen by the checker
    word_t      job_matrix = '0;
    data_type_e job_type = dt_unsigned;
    int         data_errors, chk_reads, chk_writes, chk_pending;
    int         proto_errors = 0;
    int         ready_pulses = 0;

    // Job table with vector count, signed type, extreme operands and random stalls
    int job_vecs    [num_jobs] = '{6, 5, 4, 4, 0, 12, 12, 1};
    bit job_signed  [num_jobs] = '{1, 0, 0, 1, 1, 1, 0, 1};
    bit job_extreme [num_jobs] = '{0, 0, 1, 1, 0, 0, 0, 0};
    bit job_stress  [num_jobs] = '{0, 0, 0, 0, 1, 1, 1, 1};

    always #2 clk = ~clk;

    dtpu_core dtpu_core_i (.*);

    dtpu_checker dtpu_checker_i (
        .clk           (clk),
        .reset         (reset),
        .job_matrix    (job_matrix),
        .job_type      (job_type),
        .infifo_read   (infifo_read),
        .infifo_dout   (infifo_dout),
        .outfifo_write (outfifo_write),
        .outfifo_din   (outfifo_din),
        .error_count   (data_errors),
        .read_count    (chk_reads),
        .write_count   (chk_writes),
        .pending       (chk_pending)
    );

    ///////////////////////////////
    // Models on the clock edges
    ///////////////////////////////

    // Pops and read addresses taken as the core issues them
    always @(posedge clk) begin
        if (infifo_read && in_queue.size() != 0) begin
            void'(in_queue.pop_front());
        end
        if (csr_ce) begin
            csr_rd_addr = csr_address;
        end
        if (wm_ce) begin
            wm_rd_addr = wm_address;
        end
        if (!reset && cs_ready) begin
            ready_pulses++;
        end
    end

    // Memory data, FIFO flags and enable drops on the falling edge
    task automatic drive_environment();
        forever begin
            @(negedge clk);
            enable          = !(stress && $urandom_range(99) < 10);
            infifo_is_empty = (in_queue.size() == 0) || (stress && $urandom_range(99) < 30);
            infifo_dout     = (in_queue.size() != 0) ? in_queue[0] : {2{32'hdead_beef}};
            outfifo_is_full = stress && ($urandom_range(99) < 30);
            csr_dout        = csr_mem[csr_rd_addr];
            wm_dout         = wm_mem[wm_rd_addr];
        end
    endtask

    // One observed value against its expected value
    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
        if (got !== expected) begin
            $display("ERR %s: got %h, expected %h", name, got, expected);
            proto_errors++;
        end
    endtask

    task automatic run_job(input int j);
        word_t       ext;
        logic [7:0]  index;
        int          reads0;
        int          writes0;
        int          ready0;
        // Largest products for the type
        if (job_signed[j]) begin
            ext = {16{4'h8}};
        end else begin
            ext = '1;
        end
        index      = 8'($urandom_range(255));
        job_type   = data_type_e'(job_signed[j]);
        job_matrix = job_extreme[j] ? ext : {$urandom(), $urandom()};
        wm_mem[index] = job_matrix;
        csr_mem[csr_off_count] = 8'(job_vecs[j]);
        csr_mem[csr_off_index] = index;
        csr_mem[csr_off_type]  = 8'(job_type);
        for (int i = 0; i < job_vecs[j]; i++) begin
            in_queue.push_back((job_extreme[j] && i % 2 == 0) ? ext : {$urandom(), $urandom()});
        end
        stress  = job_stress[j];
        reads0  = chk_reads;
        writes0 = chk_writes;
        ready0  = ready_pulses;

        // Start level held until the core leaves idle
        cs_start = 1'b1;
        do @(negedge clk); while (cs_idle);
        cs_start = 1'b0;
        while (!cs_done) begin
            compare_value("cs_idle", cs_idle, 1'b0);
            @(negedge clk);
        end
        // Let done sit for a few cycles before continuing
        repeat (3) @(negedge clk);
        cs_continue = 1'b1;
        do @(negedge clk); while (!cs_idle);
        cs_continue = 1'b0;

        compare_value("infifo_read count", chk_reads - reads0, job_vecs[j]);
        compare_value("outfifo_write count", chk_writes - writes0, job_vecs[j]);
        compare_value("cs_ready pulse count", ready_pulses - ready0, 1);
        if (chk_pending != 0 || in_queue.size() != 0) begin
            $display("Job %0d ended with vectors or results left over", j);
            proto_errors++;
        end
    endtask

    ///////////////////////////////
    // Sequence and watchdog
    ///////////////////////////////

    initial begin
        void'($urandom(45));
        reset           = 1'b1;
        enable          = 1'b1;
        cs_start        = 1'b0;
        cs_continue     = 1'b0;
        infifo_is_empty = 1'b1;
        infifo_dout     = '0;
        outfifo_is_full = 1'b0;
        csr_dout        = '0;
        wm_dout         = '0;
        // Fill patterns that change with every address bit
        for (int a = 0; a < 1024; a++) begin
            csr_mem[a] = 8'((a * 37) ^ (a >> 8));
        end
        for (int a = 0; a < 8192; a++) begin
            wm_mem[a] = {4{16'(a * 40503 + 4660)}};
        end
        fork
            drive_environment();
        join_none

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // Outputs straight out of reset
        compare_value("cs_idle", cs_idle, 1'b1);
        compare_value("cs_done", cs_done, 1'b0);
        compare_value("cs_ready", cs_ready, 1'b0);
        compare_value("state", state, st_idle);
        compare_value("csr_ce", csr_ce, 1'b0);
        compare_value("wm_ce", wm_ce, 1'b0);
        compare_value("infifo_read", infifo_read, 1'b0);
        compare_value("outfifo_write", outfifo_write, 1'b0);

        for (int j = 0; j < num_jobs; j++) begin
            run_job(j);
        end
        repeat (4) @(negedge clk);

        $display("data errors %0d, protocol errors %0d, assertion errors %0d",
                 data_errors, proto_errors, dtpu_core_i.dtpu_assert_i.fail_count);
        if (data_errors + proto_errors + dtpu_core_i.dtpu_assert_i.fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        limit = 10;
        foreach (job_vecs[j]) begin
            limit += 40 + 10 * job_vecs[j];
        end
        repeat (limit) @(posedge clk);
        $display("Timeout, job sequence not finished after %0d cycles", limit);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: sim.f
hw/dtpu_pkg.sv
hw/mac_row.sv
hw/mxu.sv
hw/control_unit.sv
hw/dtpu_core.sv
verification/dtpu_checker.sv
verification/dtpu_assert.sv
verification/dtpu_tb.sv
